// File: files.f
+incdir+include
hw/mvuPkg.sv
hw/dspPkg.sv
hw/laneControl.sv
hw/operandPacker.sv
hw/dspSlice.sv
hw/peChain.sv
hw/mvuTop.sv
tb/tbMvu.sv

// File: run.sh
#!/bin/sh
# build the MVU testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tbMvu -f files.f -o simv
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

out=$(./obj_dir/simv)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "ALL TESTS PASSED"; then
	exit 0
fi
exit 1

// File: tb/tbMvu.sv
`timescale 1ns/1ps
`default_nettype none

`include "mvu_consts.svh"

module tbMvu;

	localparam int CLK_PERIOD = 100;
	localparam int TOTAL_VEC = 24 + 160 + 60 + 80 + 36;     // upper bound per test, summed
	localparam int WATCHDOG_NS = TOTAL_VEC * 4 * CLK_PERIOD;
	localparam int DRAIN_MAX = 8;

	logic clk = 1'b0;               // starts low so time 0 has no clock edge
	logic rst;
	logic en;
	logic last;
	logic zero;
	mvuPkg::actVecT act;
	mvuPkg::wgtMatT wgt;
	logic valid;
	mvuPkg::resVecT result;

	logic [31:0] lfsrState;
	longint runSum [`MVU_PE];       // model sums of the open run
	logic [2:0] lastPipe;           // model of last moving toward valid
	logic rstSeen;                  // previous edge was a reset edge
	mvuPkg::resVecT expQ [$];       // closed runs not yet shown
	int errCount;                   // written by the checker only
	int seqErrors;                  // written by the stimulus process only
	int checkCount;
	int resultsSeen;
	int passCount;
	int failCount;

	mvuTop UUT (
		.clk(clk),
		.rst(rst),
		.en_i(en),
		.last_i(last),
		.zero_i(zero),
		.act_i(act),
		.wgt_i(wgt),
		.valid_o(valid),
		.result_o(result)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// fibonacci lfsr, taps 32 22 2 1, one step per bit handed out
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		logic fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
			v = {v[30:0], lfsrState[31]};
			lfsrState = {lfsrState[30:0], fb};
		end
		return v;
	endfunction

	task automatic checkValid(input logic got, input logic exp, input string what);
		checkCount++;
		if (got !== exp) begin
			$display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
			errCount++;
		end
	endtask

	task automatic checkResult(input mvuPkg::resVecT got, input mvuPkg::resVecT exp,
			input string what);
		checkCount++;
		if (got !== exp) begin
			$display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
			errCount++;
		end
	endtask

	// reference model, reads the inputs as the DUT samples them on this edge
	always @(posedge clk) begin : model
		mvuPkg::resVecT snap;
		rstSeen = rst;
		if (rst) begin
			lastPipe = '0;
			expQ.delete();
			for (int p = 0; p < `MVU_PE; p++) begin
				runSum[p] = 0;
			end
		end else if (en) begin
			if (lastPipe[2]) begin
				void'(expQ.pop_front());        // shown result moves on
			end
			if (!zero) begin
				for (int p = 0; p < `MVU_PE; p++) begin
					for (int k = 0; k < `MVU_SIMD; k++) begin
						runSum[p] += longint'($signed(act[k])) * longint'($signed(wgt[p][k]));
					end
				end
			end
			if (last) begin
				for (int p = 0; p < `MVU_PE; p++) begin
					snap[p] = mvuPkg::accuT'(runSum[p]);    // wrap to result width
					runSum[p] = 0;
				end
				expQ.push_back(snap);
			end
			lastPipe = {lastPipe[1:0], last};
		end
	end

	// outputs are settled half a period after the edge
	always @(negedge clk) begin
		checkValid(valid, lastPipe[2], "valid_o");
		if (rstSeen) begin
			checkResult(result, '0, "result_o after reset");
		end else if (lastPipe[2]) begin
			if (expQ.size() == 0) begin
				$display("at %0t the model holds no result although valid is due", $time);
				errCount++;
			end else begin
				checkResult(result, expQ[0], "result_o");
				resultsSeen++;
			end
		end
	end

	task automatic applyCycle(input logic enV, input logic lastV, input logic zeroV,
			input mvuPkg::actVecT a, input mvuPkg::wgtMatT w);
		@(posedge clk);
		rst <= 1'b0;
		en <= enV;
		last <= lastV;
		zero <= zeroV;
		act <= a;
		wgt <= w;
	endtask

	task automatic randomOperands(output mvuPkg::actVecT a, output mvuPkg::wgtMatT w);
		for (int k = 0; k < `MVU_SIMD; k++) begin
			a[k] = mvuPkg::actT'(randBits(`MVU_ACT_W));
		end
		for (int p = 0; p < `MVU_PE; p++) begin
			for (int k = 0; k < `MVU_SIMD; k++) begin
				w[p][k] = mvuPkg::wgtT'(randBits(`MVU_WGT_W));
			end
		end
	endtask

	task automatic uniformOperands(input mvuPkg::actT aVal, input mvuPkg::wgtT wVal,
			output mvuPkg::actVecT a, output mvuPkg::wgtMatT w);
		for (int p = 0; p < `MVU_PE; p++) begin
			for (int k = 0; k < `MVU_SIMD; k++) begin
				a[k] = aVal;
				w[p][k] = wVal;
			end
		end
	endtask

	task automatic pulseReset(input int cycles);
		repeat (cycles) begin
			@(posedge clk);
			rst <= 1'b1;
			en <= 1'b1;                     // reset must win over a live pipe
			last <= 1'b1;
			zero <= 1'b0;
		end
	endtask

	// idle zero-flagged vectors until every closed run has been shown
	task automatic drainResults();
		int n;
		n = 0;
		while ((expQ.size() != 0 || lastPipe != 3'b000) && n < DRAIN_MAX) begin
			applyCycle(1'b1, 1'b0, 1'b1, '0, '0);
			@(negedge clk);
			n++;
		end
		if (expQ.size() != 0) begin
			$display("results still pending after %0d idle cycles", n);
			seqErrors++;
		end
	endtask

	task automatic finishTest(input string name, input int errBefore, input int resBefore);
		@(posedge clk);                     // checker of the last negedge is done
		if (errCount + seqErrors == errBefore) begin
			passCount++;
			$display("test %s: ok, %0d results", name, resultsSeen - resBefore);
		end else begin
			failCount++;
			$display("test %s: failed, %0d errors", name, errCount + seqErrors - errBefore);
		end
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		mvuPkg::actVecT a;
		mvuPkg::wgtMatT w;
		int errBefore;
		int resBefore;
		int runLen;
		rst = 1'b1;
		en = 1'b0;
		last = 1'b0;
		zero = 1'b0;
		act = '0;
		wgt = '0;
		lfsrState = 32'he7cc;
		lastPipe = '0;
		rstSeen = 1'b0;
		errCount = 0;
		seqErrors = 0;
		checkCount = 0;
		resultsSeen = 0;
		passCount = 0;
		failCount = 0;
		@(posedge clk);                     // second reset edge comes with the first vector

		// single vectors, corner operands first
		errBefore = errCount + seqErrors;
		resBefore = resultsSeen;
		for (int i = 0; i < 24; i++) begin
			if (i == 0) uniformOperands(mvuPkg::actT'(-128), mvuPkg::wgtT'(-32), a, w);
			else if (i == 1) uniformOperands(mvuPkg::actT'(127), mvuPkg::wgtT'(31), a, w);
			else if (i == 2) uniformOperands(mvuPkg::actT'(-128), mvuPkg::wgtT'(31), a, w);
			else randomOperands(a, w);
			applyCycle(1'b1, 1'b1, 1'b0, a, w);
		end
		drainResults();
		finishTest("single", errBefore, resBefore);

		// runs of 1 to 8 vectors
		errBefore = errCount + seqErrors;
		resBefore = resultsSeen;
		for (int r = 0; r < 20; r++) begin
			runLen = 1 + int'(randBits(3));
			for (int i = 0; i < runLen; i++) begin
				randomOperands(a, w);
				applyCycle(1'b1, i == runLen - 1, 1'b0, a, w);
			end
		end
		drainResults();
		finishTest("accumulate", errBefore, resBefore);

		// zero strobe, vector 5 is both zero-flagged and last
		errBefore = errCount + seqErrors;
		resBefore = resultsSeen;
		for (int i = 0; i < 60; i++) begin
			randomOperands(a, w);
			applyCycle(1'b1, (i == 5) || (i == 59) || (randBits(2) == 32'd0),
				(i == 5) || (randBits(2) == 32'd0), a, w);
		end
		drainResults();
		finishTest("zero strobe", errBefore, resBefore);

		// random stalls, garbage on last and zero while en is low
		errBefore = errCount + seqErrors;
		resBefore = resultsSeen;
		for (int i = 0; i < 80; i++) begin
			if (randBits(2) == 32'd0) begin
				runLen = 1 + int'(randBits(2));
				for (int s = 0; s < runLen; s++) begin
					randomOperands(a, w);
					applyCycle(1'b0, randBits(1) == 32'd1, randBits(1) == 32'd1, a, w);
				end
			end
			randomOperands(a, w);
			applyCycle(1'b1, (i == 79) || (randBits(2) == 32'd0), randBits(3) == 32'd0, a, w);
		end
		drainResults();
		finishTest("stalls", errBefore, resBefore);

		// reset while a result is in flight and a run is open
		errBefore = errCount + seqErrors;
		resBefore = resultsSeen;
		for (int r = 0; r < 3; r++) begin
			for (int i = 0; i < 5; i++) begin
				randomOperands(a, w);
				applyCycle(1'b1, i == 3, 1'b0, a, w);
			end
			pulseReset(2);
			for (int i = 0; i < 4; i++) begin
				randomOperands(a, w);
				applyCycle(1'b1, i == 3, 1'b0, a, w);
			end
		end
		drainResults();
		finishTest("reset", errBefore, resBefore);

		$display("tests: %0d ok, %0d failed; checks: %0d, errors: %0d",
			passCount, failCount, checkCount, errCount + seqErrors);
		if (failCount == 0 && errCount + seqErrors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule : tbMvu

`default_nettype wire

// File: hw/mvuTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "mvu_consts.svh"

// matrix-vector engine, PE rows of slice chains sharing one activation vector
module mvuTop (
	input wire logic clk,
	input wire logic rst,
	input wire logic en_i,                  // level, low stalls the whole pipe
	input wire logic last_i,                // closes the current run
	input wire logic zero_i,                // drop this vector from the sum
	input wire mvuPkg::actVecT act_i,       // shared activation vector
	input wire mvuPkg::wgtMatT wgt_i,       // one weight row per PE
	output logic valid_o,                   // one enabled cycle per run
	output mvuPkg::resVecT result_o
);

	logic prodZero;
	logic accClear;
	dspPkg::actSlotT aSlots [`MVU_CHAINLEN];    // packed once, fanned out to all PEs
	mvuPkg::accuT peRes [`MVU_PE];

	laneControl ctrl (
		.clk(clk),
		.rst(rst),
		.en_i(en_i),
		.last_i(last_i),
		.zero_i(zero_i),
		.valid_o(valid_o),
		.accClear_o(accClear),
		.prodZero_o(prodZero)
	);

	operandPacker #(
		.elemT(mvuPkg::actT),
		.slotT(dspPkg::actSlotT),
		.LANE_W(`MVU_ACT_LANE_W)
	) actPacker (
		.elems_i(act_i),
		.slots_o(aSlots)
	);

	for (genvar p = 0; p < `MVU_PE; p++) begin : genPe
		peChain pe (
			.clk(clk),
			.rst(rst),
			.en_i(en_i),
			.aSlots_i(aSlots),
			.wgtRow_i(wgt_i[p]),
			.prodZero_i(prodZero),
			.accClear_i(accClear),
			.result_o(peRes[p])
		);
	end

	always_comb begin
		for (int p = 0; p < `MVU_PE; p++) begin
			result_o[p] = peRes[p];         // PE 0 lands in the low bits
		end
	end

endmodule : mvuTop

`default_nettype wire

// File: hw/peChain.sv
`timescale 1ns/1ps
`default_nettype none

`include "mvu_consts.svh"

// one PE row: weight packing plus a cascade of slices
module peChain (
	input wire logic clk,
	input wire logic rst,
	input wire logic en_i,
	input wire dspPkg::actSlotT aSlots_i [`MVU_CHAINLEN],  // shared, already packed
	input wire mvuPkg::wgtVecT wgtRow_i,                   // raw weights for this PE
	input wire logic prodZero_i,
	input wire logic accClear_i,
	output mvuPkg::accuT result_o
);

	dspPkg::wgtSlotT bSlots [`MVU_CHAINLEN];
	dspPkg::cascT cascW [`MVU_CHAINLEN+1];                 // cascW[j] feeds slice j

	// 6 bit weights widen to 8 bit lanes, last slot padded
	operandPacker #(
		.elemT(mvuPkg::wgtT),
		.slotT(dspPkg::wgtSlotT),
		.LANE_W(`MVU_WGT_LANE_W)
	) wgtPacker (
		.elems_i(wgtRow_i),
		.slots_o(bSlots)
	);

	assign cascW[0] = '0;                                  // nothing above the first slice

	for (genvar j = 0; j < `MVU_CHAINLEN; j++) begin : genSlice
		dspSlice #(
			.FIRST(j == 0),
			.LAST(j == `MVU_CHAINLEN - 1)
		) slice (
			.clk(clk),
			.rst(rst),
			.en_i(en_i),
			.aSlot_i(aSlots_i[j]),
			.bSlot_i(bSlots[j]),
			.prodZero_i(prodZero_i),
			.accClear_i(accClear_i),
			.casc_i(cascW[j]),
			.casc_o(cascW[j+1])
		);
	end

	// low bits of P, wraps like the hardware result port
	assign result_o = cascW[`MVU_CHAINLEN][`MVU_ACCU_W-1:0];

endmodule : peChain

`default_nettype wire

// File: hw/dspSlice.sv
`timescale 1ns/1ps
`default_nettype none

`include "mvu_consts.svh"

// behavioral DSP58 in INT8 mode: three 9x8 signed products per edge
module dspSlice #(
	parameter bit FIRST = 1'b1,                     // no upstream neighbour
	parameter bit LAST = 1'b1                       // owns the accumulating P reg
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic en_i,
	input wire dspPkg::actSlotT aSlot_i,            // shared activation lanes
	input wire dspPkg::wgtSlotT bSlot_i,            // this PE's weight lanes
	input wire logic prodZero_i,                    // aligned with aQ/bQ
	input wire logic accClear_i,                    // aligned with prodQ
	input wire dspPkg::cascT casc_i,                // PCIN from previous slice
	output dspPkg::cascT casc_o                     // PCOUT, or P when LAST
);

	dspPkg::actSlotT aQ;                            // A reg
	dspPkg::wgtSlotT bQ;                            // B reg
	dspPkg::cascT prodD;                            // lane products summed
	dspPkg::cascT prodQ;                            // M reg
	dspPkg::cascT cascIn;

	// stage 1, operand registers
	always_ff @(posedge clk) begin
		if (rst) begin
			aQ <= '0;
			bQ <= '0;
		end else if (en_i) begin
			aQ <= aSlot_i;
			bQ <= bSlot_i;
		end
	end

	// three signed lane products, added at full cascade width
	always_comb begin
		prodD = '0;
		for (int k = 0; k < `MVU_LANES; k++) begin
			prodD += dspPkg::cascT'($signed(aQ[k])) * dspPkg::cascT'($signed(bQ[k]));
		end
		if (prodZero_i) begin
			prodD = '0;                             // like zeroing B through INMODE
		end
	end

	// stage 2, product register
	always_ff @(posedge clk) begin
		if (rst) begin
			prodQ <= '0;
		end else if (en_i) begin
			prodQ <= prodD;
		end
	end

	assign cascIn = FIRST ? '0 : casc_i;            // Z mux picks 0 on the first slice

	if (LAST) begin : genAccu
		dspPkg::cascT accQ;                         // P reg, end of chain

		// stage 3, W mux drops the old P when a run has just closed
		always_ff @(posedge clk) begin
			if (rst) begin
				accQ <= '0;
			end else if (en_i) begin
				accQ <= (accClear_i ? '0 : accQ) + prodQ + cascIn;
			end
		end

		assign casc_o = accQ;

		// a stalled edge must not lose or double count a partial sum
		accuHoldsOnStall : assert property (
			@(posedge clk) (!rst && !en_i) |=> $stable(accQ)
		) else $error("accumulator moved while enable was low");
	end else begin : genPass
		// no P reg inside the chain, sum ripples down to the last slice
		assign casc_o = prodQ + cascIn;
	end

endmodule : dspSlice

`default_nettype wire

// File: hw/operandPacker.sv
`timescale 1ns/1ps
`default_nettype none

`include "mvu_consts.svh"

// packs SIMD elements into three-lane slice operands, combinational
module operandPacker #(
	parameter type elemT = logic signed [7:0],      // element as it arrives
	parameter type slotT = logic [26:0],            // one slice operand
	parameter int unsigned LANE_W = 9               // lane width inside slotT
) (
	input wire elemT [`MVU_SIMD-1:0] elems_i,
	output slotT slots_o [`MVU_CHAINLEN]
);

	localparam int unsigned SLOT_W = `MVU_LANES * LANE_W;

	for (genvar s = 0; s < `MVU_CHAINLEN; s++) begin : genSlot
		logic [SLOT_W-1:0] flat;                    // lanes laid out low to high

		for (genvar l = 0; l < `MVU_LANES; l++) begin : genLane
			localparam int unsigned IDX = s * `MVU_LANES + l;  // element feeding this lane

			if (IDX < `MVU_SIMD) begin : genData
				// sized cast of a signed value extends the sign bit
				assign flat[l*LANE_W +: LANE_W] = LANE_W'($signed(elems_i[IDX]));
			end else begin : genPad
				assign flat[l*LANE_W +: LANE_W] = '0;  // unused lane of partial slot
			end
		end

		assign slots_o[s] = slotT'(flat);           // same width, just retyped
	end

endmodule : operandPacker

`default_nettype wire

// File: hw/laneControl.sv
`timescale 1ns/1ps
`default_nettype none

module laneControl (
	input wire logic clk,
	input wire logic rst,
	input wire logic en_i,          // global clock enable, holds everything when low
	input wire logic last_i,        // current vector closes the run
	input wire logic zero_i,        // current vector is dropped from the sum
	output logic valid_o,           // result on the chain outputs is final
	output logic accClear_o,        // next accumulate starts from zero
	output logic prodZero_o         // force slice products to zero
);

	logic [2:0] lastQ;              // bit 0 is newest, lines up with operand regs
	logic accClearQ;
	logic prodZeroQ;

	always_ff @(posedge clk) begin
		if (rst) begin
			lastQ <= '0;
			accClearQ <= 1'b0;
			prodZeroQ <= 1'b0;
		end else if (en_i) begin
			lastQ <= {lastQ[1:0], last_i};      // shift toward the accumulator stage
			accClearQ <= lastQ[1];              // tap middle stage, one more reg
			prodZeroQ <= zero_i;                // same stage as operand regs
		end
	end

	assign valid_o = lastQ[2];                  // third enabled edge after last
	assign accClear_o = accClearQ;              // seen by the P reg one edge later
	assign prodZero_o = prodZeroQ;              // gates the multiply into M reg

	// a new result can only show up after the pipeline actually moved
	validOnEnable : assert property (
		@(posedge clk) disable iff (rst)
		$rose(valid_o) |-> $past(en_i)
	) else $error("valid rose without an enabled edge");

	// the clear tap must sit exactly on the result cycle, or results smear
	clearAlignsValid : assert property (
		@(posedge clk) disable iff (rst)
		accClear_o == valid_o
	) else $error("accumulator clear out of step with valid");

endmodule : laneControl

`default_nettype wire

// File: hw/dspPkg.sv
`default_nettype none

`include "mvu_consts.svh"

// operand formats of one INT8 mode slice
package dspPkg;

	typedef logic signed [`MVU_ACT_LANE_W-1:0] actLaneT;  // sign extended activation
	typedef logic signed [`MVU_WGT_LANE_W-1:0] wgtLaneT;  // sign extended weight

	// lane 0 sits in the low bits, like the A port layout
	typedef actLaneT [`MVU_LANES-1:0] actSlotT;           // 27 bits
	typedef wgtLaneT [`MVU_LANES-1:0] wgtSlotT;           // 24 bits

	// wide enough that chain sums never overflow before truncation
	typedef logic signed [`MVU_CASC_W-1:0] cascT;

endpackage : dspPkg

`default_nettype wire

// File: hw/mvuPkg.sv
`default_nettype none

`include "mvu_consts.svh"

// data types seen at the engine boundary
package mvuPkg;

	typedef logic signed [`MVU_ACT_W-1:0] actT;     // one activation element
	typedef logic signed [`MVU_WGT_W-1:0] wgtT;     // one weight element

	// one activation vector, shared by every PE row
	typedef actT [`MVU_SIMD-1:0] actVecT;

	// weight row of a single PE, element k meets activation k
	typedef wgtT [`MVU_SIMD-1:0] wgtVecT;

	// full weight tile, one row per PE
	typedef wgtVecT [`MVU_PE-1:0] wgtMatT;

	typedef logic signed [`MVU_ACCU_W-1:0] accuT;   // wraps modulo 2^24

	// PE results side by side, PE 0 in the low bits
	typedef accuT [`MVU_PE-1:0] resVecT;

endpackage : mvuPkg

`default_nettype wire

// File: include/mvu_consts.svh
`ifndef MVU_CONSTS_SVH
`define MVU_CONSTS_SVH

// array geometry
`define MVU_PE 4            // PE rows, one dot product each
`define MVU_SIMD 7          // elements per input vector

// user-facing element widths
`define MVU_ACT_W 8         // signed activation
`define MVU_WGT_W 6         // signed weight, narrower than a lane
`define MVU_ACCU_W 24       // result width presented at the top

// slice lane format in INT8 mode
`define MVU_LANES 3         // products summed per slice
`define MVU_ACT_LANE_W 9    // A lane, 27 bit A port split in three
`define MVU_WGT_LANE_W 8    // B lane, 24 bit B port split in three
`define MVU_CASC_W 58       // P register and cascade width

// slices per PE chain, last one may be partially filled
`define MVU_CHAINLEN ((`MVU_SIMD + `MVU_LANES - 1) / `MVU_LANES)

`endif
